// ==== files.f ====
credit_pkg.sv
link_pkg.sv
vc_arb_if.sv
vc_link_if.sv
vc_credit_counter.sv
vc_rr_arbiter.sv
credit_sender_vc.sv
credit_receiver_vc.sv
credit_link_top.sv
credit_link_checker.sv
tb_credit_link.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
  --top-module tb_credit_link \
  && ./obj_dir/Vtb_credit_link | tee /dev/stderr | grep -q "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tb_credit_link.sv ====
// Testbench for credit_link_top with its default parameters.
// Runs a table of traffic phases; per-VC queues hold every accepted flit.
// Phase expectations assume MaxCredit of 4 and four VCs.

`timescale 1ns/1ps

module tb_credit_link;
  import credit_pkg::*;
  import link_pkg::*;

  localparam int NumVcs = DEFAULT_NUM_VCS;
  localparam int Width = DEFAULT_WIDTH;
  localparam int MaxCredit = DEFAULT_MAX_CREDIT;
  localparam int NumPhases = 9;
  localparam credit_count_t Full = credit_count_t'(MaxCredit);
  localparam credit_count_t Held = credit_count_t'(1);
  localparam credit_count_t None = credit_count_t'(0);

  // One row of the phase table.
  typedef struct packed {
    logic [NumVcs-1:0]          push_mask;
    logic [NumVcs-1:0]          drain_mask;
    logic                       rnd_drain;
    logic                       fair;
    logic                       wait_idle;
    int                         cycles;
    credit_count_t [NumVcs-1:0] withhold;
    logic [NumVcs-1:0]          count_mask;
    credit_count_t [NumVcs-1:0] exp_count;
    logic [NumVcs-1:0]          ready_low;
    logic [NumVcs-1:0]          deliver;
  } phase_t;

  logic                         clk;
  logic                         reset;
  logic [NumVcs-1:0]            push_valid;
  logic [NumVcs-1:0]            push_ready;
  logic [NumVcs-1:0][Width-1:0] push_data;
  logic [NumVcs-1:0]            out_valid;
  logic [NumVcs-1:0]            out_ready;
  logic [NumVcs-1:0][Width-1:0] out_data;
  credit_count_t [NumVcs-1:0]   credit_withhold;
  credit_count_t [NumVcs-1:0]   credit_count;

  phase_t                       phases [NumPhases];
  logic [31:0]                  lfsr_state;
  logic [Width-1:0]             sent_q [NumVcs][$];
  logic [NumVcs-1:0]            pend_valid;
  logic [NumVcs-1:0][Width-1:0] pend_data;
  int                           delivered [NumVcs];
  int                           since_accept [NumVcs];

  credit_link_top UUT (
    .clk             (clk),
    .reset           (reset),
    .push_valid      (push_valid),
    .push_ready      (push_ready),
    .push_data       (push_data),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_data        (out_data),
    .credit_withhold (credit_withhold),
    .credit_count    (credit_count)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // ----------------------------------------
  // Random bits and checks.
  // ----------------------------------------

  // Fibonacci LFSR, taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr_state = lfsr_step(lfsr_state);
    b = lfsr_state[0];
  endtask

  // One LFSR step per data bit.
  task automatic take_word(output logic [Width-1:0] w);
    logic b;
    w = '0;
    for (int k = 0; k < Width; k++) begin
      take_bit(b);
      w[k] = b;
    end
  endtask

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_flit(input string name, input logic [Width-1:0] got,
                            input logic [Width-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_credit(input string name, input credit_count_t got,
                              input credit_count_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  // ----------------------------------------
  // Phase table.
  // ----------------------------------------
  task automatic load_phases();
    // push, drain, random drain, fair, wait idle, cycles, withhold,
    // count mask, expected counts, push_ready low mask, must-deliver mask.
    phases[0] = '{4'hF, 4'hF, 1'b1, 1'b0, 1'b0, 150, {4{None}}, 4'h0, {4{Full}}, 4'h0, 4'hF};
    phases[1] = '{4'h0, 4'hF, 1'b0, 1'b0, 1'b1, 40, {4{None}}, 4'hF, {4{Full}}, 4'h0, 4'h0};
    phases[2] = '{4'hF, 4'hF, 1'b0, 1'b1, 1'b0, 80, {4{None}}, 4'h0, {4{Full}}, 4'h0, 4'hF};
    phases[3] = '{4'h0, 4'hF, 1'b0, 1'b0, 1'b1, 40, {4{None}}, 4'hF, {4{Full}}, 4'h0, 4'h0};
    // VC 0 stalled, the rest keep moving.
    phases[4] = '{4'hF, 4'hE, 1'b1, 1'b0, 1'b0, 60, {4{None}}, 4'h1, {4{None}}, 4'h1, 4'hE};
    phases[5] = '{4'h0, 4'hF, 1'b0, 1'b0, 1'b1, 40, {4{None}}, 4'hF, {4{Full}}, 4'h0, 4'h1};
    // One credit withheld on VC 1, then released.
    phases[6] = '{4'h2, 4'h0, 1'b0, 1'b0, 1'b0, 30, {None, None, Held, None}, 4'h2,
                  {Full, Full, Held, Full}, 4'h2, 4'h0};
    phases[7] = '{4'h2, 4'h0, 1'b0, 1'b0, 1'b0, 20, {4{None}}, 4'h2, {4{None}}, 4'h2, 4'h0};
    phases[8] = '{4'h0, 4'hF, 1'b0, 1'b0, 1'b1, 40, {4{None}}, 4'hF, {4{Full}}, 4'h0, 4'h2};
  endtask

  // Drive on the falling edge, sample the handshakes before the rising one.
  task automatic run_cycle(input phase_t ph);
    logic b;
    @(negedge clk);
    for (int i = 0; i < NumVcs; i++) begin
      // A producer holds its flit until it is taken.
      if (!pend_valid[i] && ph.push_mask[i]) begin
        take_word(pend_data[i]);
        pend_valid[i] = 1'b1;
      end
      b = 1'b1;
      if (ph.rnd_drain) begin
        take_bit(b);
      end
      out_ready[i] = ph.drain_mask[i] && b;
    end
    push_valid = pend_valid;
    push_data = pend_data;
    credit_withhold = ph.withhold;
    #10;
    for (int i = 0; i < NumVcs; i++) begin
      if (out_valid[i] && out_ready[i]) begin
        if (sent_q[i].size() == 0) begin
          stop_with_failure($sformatf("VC %0d delivered a flit that was never sent", i));
        end
        check_flit($sformatf("out_data[%0d]", i), out_data[i], sent_q[i].pop_front());
        delivered[i]++;
      end
      if (push_valid[i] && push_ready[i]) begin
        sent_q[i].push_back(push_data[i]);
        pend_valid[i] = 1'b0;
        // Round-robin bound on how long a valid VC waits.
        for (int j = 0; j < NumVcs; j++) begin
          since_accept[j] = (j == i) ? 0 : since_accept[j] + 1;
          if (ph.fair && since_accept[j] > NumVcs) begin
            stop_with_failure($sformatf("VC %0d was passed over too often", j));
          end
        end
      end
    end
  endtask

  task automatic run_phase(input phase_t ph);
    int n;
    logic idle;
    for (int i = 0; i < NumVcs; i++) begin
      delivered[i] = 0;
      since_accept[i] = 0;
    end
    n = 0;
    idle = 1'b0;
    while (n < ph.cycles && !(ph.wait_idle && idle)) begin
      run_cycle(ph);
      idle = (push_valid == '0) && (pend_valid == '0) && (out_valid == '0) &&
             (credit_count == {NumVcs{Full}});
      n++;
    end
    if (ph.wait_idle && !idle) begin
      stop_with_failure("timeout while waiting for all credits to return");
    end
    for (int i = 0; i < NumVcs; i++) begin
      if (ph.count_mask[i]) begin
        check_credit($sformatf("credit_count[%0d]", i), credit_count[i], ph.exp_count[i]);
      end
      if (ph.ready_low[i]) begin
        check_flag($sformatf("push_ready[%0d]", i), push_ready[i], 1'b0);
      end
      if (ph.deliver[i] && delivered[i] == 0) begin
        stop_with_failure($sformatf("VC %0d delivered nothing during a phase", i));
      end
    end
  endtask

  // ----------------------------------------
  // Main sequence.
  // ----------------------------------------
  initial begin
    lfsr_state = 32'h47df025c;
    reset = 1'b1;
    push_valid = '1;
    push_data = '0;
    out_ready = '0;
    credit_withhold = '0;
    pend_valid = '0;
    pend_data = '0;
    load_phases();
    // Producers are valid during reset, yet nothing may be taken.
    for (int c = 0; c < 7; c++) begin
      @(negedge clk);
      #10;
      for (int i = 0; i < NumVcs; i++) begin
        check_flag($sformatf("push_ready[%0d]", i), push_ready[i], 1'b0);
        check_flag($sformatf("out_valid[%0d]", i), out_valid[i], 1'b0);
      end
    end
    @(negedge clk);
    reset = 1'b0;
    push_valid = '0;
    #10;
    for (int i = 0; i < NumVcs; i++) begin
      check_credit($sformatf("credit_count[%0d]", i), credit_count[i], Full);
    end
    for (int p = 0; p < NumPhases; p++) begin
      run_phase(phases[p]);
    end
    for (int i = 0; i < NumVcs; i++) begin
      if (sent_q[i].size() != 0) begin
        stop_with_failure($sformatf("VC %0d lost %0d flits", i, sent_q[i].size()));
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

// ==== credit_link_checker.sv ====
// Concurrent assertions on the credit sender, bound into credit_sender_vc.
// The channel check uses the credit the VC held when its flit was granted,
// one cycle back when the pop outputs are registered.
// Checks are off while reset is high.

`timescale 1ns/1ps

module credit_link_checker #(
  parameter int NumVcs = 2,
  parameter int MaxCredit = 4,
  parameter bit RegisterPopOutputs = 1'b0
) (
  input logic                                   clk,
  input logic                                   reset,
  input logic [NumVcs-1:0]                      request,
  input logic [NumVcs-1:0]                      grant,
  input logic                                   pop_valid,
  input link_pkg::vc_id_t                       pop_vc,
  input credit_pkg::credit_count_t [NumVcs-1:0] credit_available,
  input credit_pkg::credit_count_t [NumVcs-1:0] credit_count
);
  import credit_pkg::*;

  credit_count_t [NumVcs-1:0] launch_available;
  logic                       over_limit;

  // Available credit in the cycle the flit on the channel was granted.
  if (RegisterPopOutputs) begin : gen_launch_reg
    always_ff @(posedge clk) begin
      launch_available <= credit_available;
    end
  end else begin : gen_launch_comb
    assign launch_available = credit_available;
  end

  // Per-VC limit violations folded into one flag.
  always_comb begin
    over_limit = 1'b0;
    for (int i = 0; i < NumVcs; i++) begin
      if (credit_count[i] > credit_count_t'(MaxCredit)) begin
        over_limit = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Arbiter.
  assert property (@(posedge clk) disable iff (reset)
    $onehot0(grant) && ((request == '0) || (grant != '0)))
    else $error("grant is not one-hot or misses a pending request");

  // ----------------------------------------
  // Credits.
  assert property (@(posedge clk) disable iff (reset)
    pop_valid |-> (launch_available[pop_vc] != '0))
    else $error("flit sent on a VC without available credit");

  assert property (@(posedge clk) disable iff (reset) !over_limit)
    else $error("credit count above MaxCredit");

endmodule

bind credit_sender_vc credit_link_checker #(
  .NumVcs(NumVcs),
  .MaxCredit(MaxCredit),
  .RegisterPopOutputs(RegisterPopOutputs)
) u_checker (
  .clk              (clk),
  .reset            (reset),
  .request          (arb.request),
  .grant            (arb.grant),
  .pop_valid        (link.pop_valid),
  .pop_vc           (link.pop_vc),
  .credit_available (credit_available),
  .credit_count     (credit_count)
);

// ==== credit_link_top.sv ====
// Credit-based VC link, sender and receiver joined by one channel.
// NumVcs is 2 to 4 and MaxCredit 1 to 15.
// Producers must hold valid and data stable while push_ready is low.

`timescale 1ns/1ps

module credit_link_top #(
  parameter int NumVcs = credit_pkg::DEFAULT_NUM_VCS,
  parameter int Width = link_pkg::DEFAULT_WIDTH,
  parameter int MaxCredit = credit_pkg::DEFAULT_MAX_CREDIT,
  parameter bit RegisterPopOutputs = 1'b0
) (
  input  logic                                   clk,
  input  logic                                   reset,
  // Producer side.
  input  logic [NumVcs-1:0]                      push_valid,
  output logic [NumVcs-1:0]                      push_ready,
  input  logic [NumVcs-1:0][Width-1:0]           push_data,
  // Consumer side.
  output logic [NumVcs-1:0]                      out_valid,
  input  logic [NumVcs-1:0]                      out_ready,
  output logic [NumVcs-1:0][Width-1:0]           out_data,
  // Credit control and status.
  input  credit_pkg::credit_count_t [NumVcs-1:0] credit_withhold,
  output credit_pkg::credit_count_t [NumVcs-1:0] credit_count
);

  vc_arb_if #(.NumVcs(NumVcs)) arb_bus ();
  vc_link_if #(.NumVcs(NumVcs), .Width(Width)) link_bus ();

  credit_sender_vc #(
    .NumVcs(NumVcs),
    .Width(Width),
    .MaxCredit(MaxCredit),
    .RegisterPopOutputs(RegisterPopOutputs)
  ) u_sender (
    .clk             (clk),
    .reset           (reset),
    .push_valid      (push_valid),
    .push_ready      (push_ready),
    .push_data       (push_data),
    .credit_withhold (credit_withhold),
    .credit_count    (credit_count),
    .arb             (arb_bus),
    .link            (link_bus)
  );

  vc_rr_arbiter #(
    .NumVcs(NumVcs)
  ) u_arbiter (
    .clk   (clk),
    .reset (reset),
    .arb   (arb_bus)
  );

  credit_receiver_vc #(
    .NumVcs(NumVcs),
    .Width(Width),
    .MaxCredit(MaxCredit)
  ) u_receiver (
    .clk       (clk),
    .reset     (reset),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .link      (link_bus)
  );

endmodule

// ==== credit_receiver_vc.sv ====
// Credit receiver with one MaxCredit-deep FIFO per VC.
// Credits guarantee space, so an incoming flit is never dropped.
// The FIFOs also clear while the sender is in reset, since its counters reload.

`timescale 1ns/1ps

module credit_receiver_vc #(
  parameter int NumVcs = 2,
  parameter int Width = 16,
  parameter int MaxCredit = 4
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [NumVcs-1:0]            out_ready,
  output logic [NumVcs-1:0]            out_valid,
  output logic [NumVcs-1:0][Width-1:0] out_data,
  vc_link_if.rx                        link
);
  import link_pkg::*;

  localparam int AddrWidth = (MaxCredit > 1) ? $clog2(MaxCredit) : 1;
  localparam int CountWidth = $clog2(MaxCredit + 1);

  logic              clear;
  logic [NumVcs-1:0] rd_en;
  logic [NumVcs-1:0] pop_credit_q;

  // Circular pointer step over MaxCredit slots.
  function automatic logic [AddrWidth-1:0] next_ptr(input logic [AddrWidth-1:0] ptr);
    if (ptr == AddrWidth'(MaxCredit - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign link.receiver_in_reset = reset;
  assign clear = reset || link.sender_in_reset;

  // ----------------------------------------
  // Per-VC FIFOs.
  // ----------------------------------------
  for (genvar i = 0; i < NumVcs; i++) begin : gen_fifo
    logic [Width-1:0]      mem [MaxCredit];
    logic [AddrWidth-1:0]  wr_ptr;
    logic [AddrWidth-1:0]  rd_ptr;
    logic [CountWidth-1:0] fill;
    logic                  wr_en;

    // Steered by the VC number that travels with the flit.
    assign wr_en = link.pop_valid && (link.pop_vc == vc_id_t'(i));
    assign rd_en[i] = out_valid[i] && out_ready[i];

    // Head of the FIFO, visible the cycle after its write.
    assign out_valid[i] = fill != '0;
    assign out_data[i] = mem[rd_ptr];

    always_ff @(posedge clk) begin
      if (wr_en) begin
        mem[wr_ptr] <= link.pop_data;
      end
    end

    always_ff @(posedge clk) begin
      if (clear) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        fill <= '0;
      end else begin
        if (wr_en) begin
          wr_ptr <= next_ptr(wr_ptr);
        end
        if (rd_en[i]) begin
          rd_ptr <= next_ptr(rd_ptr);
        end
        fill <= fill + CountWidth'(wr_en) - CountWidth'(rd_en[i]);
      end
    end
  end

  // ----------------------------------------
  // Credit return.
  // ----------------------------------------

  // One pulse per popped flit, one edge after the pop.
  always_ff @(posedge clk) begin
    if (clear) begin
      pop_credit_q <= '0;
    end else begin
      pop_credit_q <= rd_en;
    end
  end

  assign link.pop_credit = pop_credit_q;

endmodule

// ==== credit_sender_vc.sv ====
// Credit sender for NumVcs producers sharing one physical channel.
// A VC only requests while it holds available credit and the receiver is
// out of reset. push_ready depends on push_valid through the arbiter.
// RegisterPopOutputs adds one cycle to pop outputs and sender_in_reset.

`timescale 1ns/1ps

module credit_sender_vc #(
  parameter int NumVcs = 2,
  parameter int Width = 16,
  parameter int MaxCredit = 4,
  parameter bit RegisterPopOutputs = 1'b0
) (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [NumVcs-1:0]                       push_valid,
  output logic [NumVcs-1:0]                       push_ready,
  input  logic [NumVcs-1:0][Width-1:0]            push_data,
  input  credit_pkg::credit_count_t [NumVcs-1:0]  credit_withhold,
  output credit_pkg::credit_count_t [NumVcs-1:0]  credit_count,
  vc_arb_if.sender                                arb,
  vc_link_if.tx                                   link
);
  import credit_pkg::*;
  import link_pkg::*;

  credit_count_t [NumVcs-1:0] credit_available;
  logic [NumVcs-1:0]          has_credit;
  logic [NumVcs-1:0]          request;
  logic [NumVcs-1:0]          accept;

  logic             internal_valid;
  logic [Width-1:0] internal_data;
  vc_id_t           internal_vc;

  // ----------------------------------------
  // Per-VC gating and credit counters.
  // ----------------------------------------
  for (genvar i = 0; i < NumVcs; i++) begin : gen_vc
    assign has_credit[i] = credit_available[i] != '0;
    // Nothing is sent into a receiver that is in reset.
    assign request[i] = push_valid[i] && has_credit[i] && !link.receiver_in_reset;
    assign push_ready[i] = arb.grant[i] && has_credit[i];
    assign accept[i] = push_valid[i] && push_ready[i];

    vc_credit_counter #(
      .MaxCredit(MaxCredit)
    ) u_counter (
      .clk       (clk),
      .reset     (reset),
      .reinit    (link.receiver_in_reset),
      .incr      (link.pop_credit[i]),
      .decr      (accept[i]),
      .withhold  (credit_withhold[i]),
      .count     (credit_count[i]),
      .available (credit_available[i])
    );
  end

  assign arb.request = request;
  // No back-pressure on the channel, so it is free every cycle.
  assign arb.enable_priority_update = 1'b1;

  // ----------------------------------------
  // Flit mux and VC encode.
  // ----------------------------------------

  // AND-OR mux, grant is at most one-hot.
  always_comb begin
    internal_data = '0;
    internal_vc = '0;
    for (int i = 0; i < NumVcs; i++) begin
      if (arb.grant[i]) begin
        internal_data = internal_data | push_data[i];
        internal_vc = internal_vc | vc_id_t'(i);
      end
    end
  end

  assign internal_valid = |arb.grant;

  // ----------------------------------------
  // Optional pop register.
  // ----------------------------------------
  if (RegisterPopOutputs) begin : gen_pop_reg
    logic             pop_valid_q;
    logic [Width-1:0] pop_data_q;
    vc_id_t           pop_vc_q;
    logic             sender_in_reset_q;

    always_ff @(posedge clk) begin
      if (reset) begin
        pop_valid_q <= 1'b0;
      end else begin
        pop_valid_q <= internal_valid;
      end
    end

    // Payload and the delayed reset flag.
    always_ff @(posedge clk) begin
      pop_data_q <= internal_data;
      pop_vc_q <= internal_vc;
      sender_in_reset_q <= reset;
    end

    assign link.pop_valid = pop_valid_q;
    assign link.pop_data = pop_data_q;
    assign link.pop_vc = pop_vc_q;
    assign link.sender_in_reset = sender_in_reset_q;
  end else begin : gen_pop_comb
    assign link.pop_valid = internal_valid;
    assign link.pop_data = internal_data;
    assign link.pop_vc = internal_vc;
    assign link.sender_in_reset = reset;
  end

endmodule

// ==== vc_rr_arbiter.sv ====
// Round-robin arbiter for the VC requests.
// Grant is combinational from request. The pointer only moves on an
// enabled priority update with a grant.

`timescale 1ns/1ps

module vc_rr_arbiter #(
  parameter int NumVcs = 2
) (
  input logic       clk,
  input logic       reset,
  vc_arb_if.arbiter arb
);

  // One-hot, last VC that won.
  logic [NumVcs-1:0] last_winner;
  int                last_idx;

  // Index of the last winner.
  always_comb begin
    last_idx = NumVcs - 1;
    for (int i = 0; i < NumVcs; i++) begin
      if (last_winner[i]) begin
        last_idx = i;
      end
    end
  end

  // Walk from the VC after the last winner, in circular order.
  // can_grant stays high up to and including the first requester.
  always_comb begin
    int   idx;
    logic blocked;
    blocked = 1'b0;
    arb.can_grant = '0;
    for (int k = 1; k <= NumVcs; k++) begin
      idx = last_idx + k;
      if (idx >= NumVcs) begin
        idx = idx - NumVcs;
      end
      arb.can_grant[idx] = !blocked;
      blocked = blocked | arb.request[idx];
    end
  end

  assign arb.grant = arb.request & arb.can_grant;

  // After reset VC 0 has top priority.
  always_ff @(posedge clk) begin
    if (reset) begin
      last_winner <= '0;
      last_winner[NumVcs-1] <= 1'b1;
    end else if (arb.enable_priority_update && (|arb.grant)) begin
      last_winner <= arb.grant;
    end
  end

endmodule

// ==== vc_credit_counter.sv ====
// Credit counter for a single VC.
// At most one credit is returned and one taken per cycle.
// The caller must not decrement while available is zero.

`timescale 1ns/1ps

module vc_credit_counter #(
  parameter int MaxCredit = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      reinit,
  input  logic                      incr,
  input  logic                      decr,
  input  credit_pkg::credit_count_t withhold,
  output credit_pkg::credit_count_t count,
  output credit_pkg::credit_count_t available
);
  import credit_pkg::*;

  // Reload value, clamped to what the count type can hold.
  localparam credit_count_t InitCount =
    credit_count_t'((MaxCredit > MAX_CREDIT_LIMIT) ? MAX_CREDIT_LIMIT : MaxCredit);

  credit_count_t next_count;

  // ----------------------------------------
  // Count update.
  // ----------------------------------------

  // Simultaneous incr and decr cancel out.
  always_comb begin
    next_count = count;
    if (incr && !decr) begin
      next_count = count + credit_count_t'(1);
    end else if (decr && !incr) begin
      next_count = count - credit_count_t'(1);
    end
  end

  // Reinit follows the far side's reset, so both ends restart together.
  always_ff @(posedge clk) begin
    if (reset || reinit) begin
      count <= InitCount;
    end else begin
      count <= next_count;
    end
  end

  // ----------------------------------------
  // Available credit.
  // ----------------------------------------

  // Withheld credits are hidden from the sender, floored at zero.
  always_comb begin
    if (count > withhold) begin
      available = count - withhold;
    end else begin
      available = '0;
    end
  end

endmodule

// ==== vc_link_if.sv ====
// Shared physical channel plus per-VC credit return.
// pop_valid has no ready. The receiver must take every flit it is sent.

`timescale 1ns/1ps

interface vc_link_if #(
  parameter int NumVcs = 2,
  parameter int Width = 16
);
  import link_pkg::*;

  // ----------------------------------------
  // Sender to receiver.
  logic             pop_valid;
  logic [Width-1:0] pop_data;
  vc_id_t           pop_vc;
  logic             sender_in_reset;

  // Receiver to sender, one credit pulse per VC.
  logic [NumVcs-1:0] pop_credit;
  logic              receiver_in_reset;

  modport tx (output pop_valid, output pop_data, output pop_vc, output sender_in_reset,
              input pop_credit, input receiver_in_reset);
  modport rx (input pop_valid, input pop_data, input pop_vc, input sender_in_reset,
              output pop_credit, output receiver_in_reset);

endinterface

// ==== vc_arb_if.sv ====
// Request and grant bundle between the credit sender and its arbiter.
// The arbiter must keep grant equal to request masked by can_grant.

`timescale 1ns/1ps

interface vc_arb_if #(
  parameter int NumVcs = 2
);

  logic [NumVcs-1:0] request;
  logic [NumVcs-1:0] can_grant;
  logic [NumVcs-1:0] grant;
  logic              enable_priority_update;

  modport sender (output request, output enable_priority_update,
                  input can_grant, input grant);
  modport arbiter (input request, input enable_priority_update,
                   output can_grant, output grant);

endinterface

// ==== link_pkg.sv ====
// Flit and VC identifier types for the shared physical channel.
// The VC number is VC_ID_BITS wide, so NumVcs can be at most 4.

package link_pkg;

  // Width of the VC number sent with each flit.
  localparam int VC_ID_BITS = 2;

  // VC number that travels next to the flit data.
  typedef logic [VC_ID_BITS-1:0] vc_id_t;

  // Default flit data width.
  localparam int DEFAULT_WIDTH = 16;

endpackage

// ==== credit_pkg.sv ====
// Credit types and default limits for the VC link.
// A counter holds at most MAX_CREDIT_LIMIT credits. Larger MaxCredit values
// are clamped by the counter.

package credit_pkg;

  // Largest supported per-VC buffer depth.
  localparam int MAX_CREDIT_LIMIT = 15;

  // Credit count wide enough for MAX_CREDIT_LIMIT.
  typedef logic [$clog2(MAX_CREDIT_LIMIT + 1)-1:0] credit_count_t;

  // Defaults used by the top level.
  localparam int DEFAULT_NUM_VCS = 4;
  localparam int DEFAULT_MAX_CREDIT = 4;

endpackage
